// File: files.f
hdl/synth_config_pkg.sv
hdl/envelope_pkg.sv
hdl/voice_control_if.sv
hdl/adsr_register_file.sv
hdl/sample_tick_generator.sv
hdl/reciprocal_rom.sv
hdl/adsr_envelope.sv
hdl/phase_oscillator.sv
hdl/voice_amplifier.sv
hdl/synth_voice_top.sv
testbench/synth_voice_tb.sv

// File: hdl/adsr_envelope.sv
`timescale 1ns/10ps

module adsr_envelope
  import synth_config_pkg::*, envelope_pkg::*;
(
  input  logic                              clock_50_000_000,
  input  logic                              reset_l,
  input  logic                              sample_tick,
  voice_control_if.envelope                 control,
  output logic [ENVELOPE_COUNTER_WIDTH-1:0] divisor,
  input  logic [ENVELOPE_COUNTER_WIDTH-1:0] reciprocal,
  output logic [AUDIO_BIT_WIDTH-1:0]        envelope,
  output logic                              envelope_end
);

  envelope_state_t state;

  logic [ENVELOPE_COUNTER_WIDTH-1:0]   count;
  logic [ENVELOPE_COUNTER_WIDTH-1:0]   attack_target;
  logic [ENVELOPE_COUNTER_WIDTH-1:0]   decay_target;
  logic [ENVELOPE_COUNTER_WIDTH-1:0]   release_target;
  logic [ENVELOPE_COUNTER_WIDTH-1:0]   remaining;
  logic [2*ENVELOPE_COUNTER_WIDTH-1:0] attack_product;
  logic [ENVELOPE_COUNTER_WIDTH-1:0]   attack_scaled;
  logic [31:0]                         decay_span;
  logic [31:0]                         decay_sum;
  logic [31:0]                         release_product;
  logic [31:0]                         release_scaled;
  logic [AUDIO_BIT_WIDTH-1:0]          sustain_height;
  logic [AUDIO_BIT_WIDTH-1:0]          release_height;
  logic [AUDIO_BIT_WIDTH-1:0]          attack_level;
  logic [AUDIO_BIT_WIDTH-1:0]          decay_level;
  logic [AUDIO_BIT_WIDTH-1:0]          release_level;

  // stage length in samples for a percent setting
  function automatic logic [ENVELOPE_COUNTER_WIDTH-1:0] stage_target(
    input logic [PERCENT_WIDTH-1:0] setting
  );
    return ENVELOPE_COUNTER_WIDTH'((MAX_TARGET_TICKS * 32'(setting)) >> PERCENT_WIDTH);
  endfunction

  assign attack_target  = stage_target(control.parameters.attack_time);
  assign decay_target   = stage_target(control.parameters.decay_time);
  assign release_target = stage_target(control.parameters.release_time);
  assign sustain_height = {control.parameters.sustain_level,
                           {(AUDIO_BIT_WIDTH - PERCENT_WIDTH){1'b0}}};

  // rom is addressed by the active stage length
  always_comb begin
    case (state)
      ATTACK:  divisor = attack_target;
      DECAY:   divisor = decay_target;
      RELEASE: divisor = release_target;
      default: divisor = '0;
    endcase
  end

  assign remaining = (count >= divisor) ? '0 : divisor - count;

  // ----------------------------------------------------------
  // stage shapes
  // ----------------------------------------------------------
  // attack rises as count / target
  assign attack_product = count * reciprocal;
  assign attack_scaled  = (|attack_product[2*ENVELOPE_COUNTER_WIDTH-1:ENVELOPE_COUNTER_WIDTH])
                          ? '1 : attack_product[ENVELOPE_COUNTER_WIDTH-1:0];
  assign attack_level   = {attack_scaled, {ENVELOPE_PUSH_BITS{1'b0}}};

  // decay closes the gap above sustain height
  assign decay_span  = (PARAM_CEILING - 32'(control.parameters.sustain_level))
                       * 32'(reciprocal) * 32'(remaining);
  assign decay_sum   = 32'(sustain_height) + decay_span;
  assign decay_level = (|decay_sum[31:AUDIO_BIT_WIDTH]) ? '1 : decay_sum[AUDIO_BIT_WIDTH-1:0];

  // release scales the captured height down to zero
  assign release_product = 32'(release_height) * 32'(reciprocal) * 32'(remaining);
  assign release_scaled  = release_product >> ENVELOPE_COUNTER_WIDTH;
  assign release_level   = (release_scaled > 32'(release_height))
                           ? release_height : release_scaled[AUDIO_BIT_WIDTH-1:0];

  // ----------------------------------------------------------
  // FSM
  // ----------------------------------------------------------
  always_ff @(posedge clock_50_000_000, negedge reset_l) begin
    if (!reset_l) begin
      state    <= IDLE;
      count    <= '0;
      envelope <= '0;
    end else if (control.note_on) begin
      state    <= ATTACK;
      count    <= '0;
      envelope <= '0;
    end else if (control.note_off && state != IDLE) begin
      state <= RELEASE;
      count <= '0;
    end else if (sample_tick) begin
      case (state)
        ATTACK: begin
          envelope <= attack_level;
          count    <= count + 1'b1;
          if (count >= attack_target) begin
            state <= DECAY;
            count <= '0;
          end
        end
        DECAY: begin
          envelope <= decay_level;
          count    <= count + 1'b1;
          if (count >= decay_target) begin
            state <= SUSTAIN;
            count <= '0;
          end
        end
        SUSTAIN: envelope <= sustain_height;
        RELEASE: begin
          envelope <= release_level;
          count    <= count + 1'b1;
          if (count >= release_target) begin
            state <= IDLE;
            count <= '0;
          end
        end
        default: envelope <= '0;
      endcase
    end
  end

  // starting point of the release ramp
  always_ff @(posedge clock_50_000_000) begin
    if (control.note_off && state != IDLE) begin
      release_height <= envelope;
    end
  end

  assign envelope_end = (state == IDLE);

  a_notes_exclusive: assert property (
    @(posedge clock_50_000_000) disable iff (!reset_l)
    !(control.note_on && control.note_off)
  ) else $error("note_on and note_off in the same cycle");

  a_end_means_silent: assert property (
    @(posedge clock_50_000_000) disable iff (!reset_l)
    envelope_end |-> (envelope == '0)
  ) else $error("envelope_end high with nonzero envelope");

endmodule

// File: hdl/adsr_register_file.sv
`timescale 1ns/10ps

module adsr_register_file
  import synth_config_pkg::*, envelope_pkg::*;
(
  input  logic                      clock_50_000_000,
  input  logic                      reset_l,
  input  logic [APB_ADDR_WIDTH-1:0] paddr,
  input  logic                      psel,
  input  logic                      penable,
  input  logic                      pwrite,
  input  logic [31:0]               pwdata,
  output logic [31:0]               prdata,
  output logic                      pready,
  output logic                      pslverr,
  input  logic                      envelope_end,
  voice_control_if.source           control
);

  logic access;
  logic mapped;
  logic write_enable;
  logic command_write;

  assign access = psel && penable;
  assign pready = 1'b1;

  // ----------------------------------------------------------
  // address decode and read mux
  // ----------------------------------------------------------
  always_comb begin
    mapped = 1'b1;
    prdata = '0;
    case (paddr)
      ATTACK_ADDR:          prdata = 32'(control.parameters.attack_time);
      DECAY_ADDR:           prdata = 32'(control.parameters.decay_time);
      SUSTAIN_ADDR:         prdata = 32'(control.parameters.sustain_level);
      RELEASE_ADDR:         prdata = 32'(control.parameters.release_time);
      PHASE_INCREMENT_ADDR: prdata = 32'(control.phase_increment);
      COMMAND_ADDR:         prdata = '0;
      STATUS_ADDR:          prdata = 32'(envelope_end);
      default:              mapped = 1'b0;
    endcase
  end

  // status is read only
  assign pslverr = access && (!mapped || (pwrite && paddr == STATUS_ADDR));

  assign write_enable  = access && pwrite && !pslverr;
  assign command_write = write_enable && paddr == COMMAND_ADDR;

  // ----------------------------------------------------------
  // settings and note pulses
  // ----------------------------------------------------------
  always_ff @(posedge clock_50_000_000, negedge reset_l) begin
    if (!reset_l) begin
      control.parameters      <= '0;
      control.phase_increment <= '0;
      control.note_on         <= 1'b0;
      control.note_off        <= 1'b0;
    end else begin
      // note_on wins when both bits are set
      control.note_on  <= command_write && pwdata[COMMAND_NOTE_ON_BIT];
      control.note_off <= command_write && pwdata[COMMAND_NOTE_OFF_BIT]
                          && !pwdata[COMMAND_NOTE_ON_BIT];
      if (write_enable) begin
        case (paddr)
          ATTACK_ADDR:
            control.parameters.attack_time <= pwdata[PERCENT_WIDTH-1:0];
          DECAY_ADDR:
            control.parameters.decay_time <= pwdata[PERCENT_WIDTH-1:0];
          SUSTAIN_ADDR:
            control.parameters.sustain_level <= pwdata[PERCENT_WIDTH-1:0];
          RELEASE_ADDR:
            control.parameters.release_time <= pwdata[PERCENT_WIDTH-1:0];
          PHASE_INCREMENT_ADDR:
            control.phase_increment <= pwdata[PHASE_WIDTH-1:0];
          default: ;
        endcase
      end
    end
  end

  a_penable_needs_psel: assert property (
    @(posedge clock_50_000_000) disable iff (!reset_l)
    penable |-> psel
  ) else $error("apb penable high without psel");

endmodule

// File: hdl/envelope_pkg.sv
package envelope_pkg;

  import synth_config_pkg::*;

  typedef struct packed {
    logic [PERCENT_WIDTH-1:0] attack_time;
    logic [PERCENT_WIDTH-1:0] decay_time;
    logic [PERCENT_WIDTH-1:0] sustain_level;
    logic [PERCENT_WIDTH-1:0] release_time;
  } parameter_t;

  typedef enum logic [2:0] {
    IDLE,
    ATTACK,
    DECAY,
    SUSTAIN,
    RELEASE
  } envelope_state_t;

  // ----------------------------------------------------------
  // APB register map
  // ----------------------------------------------------------
  localparam int APB_ADDR_WIDTH = 8;

  localparam logic [APB_ADDR_WIDTH-1:0] ATTACK_ADDR          = 8'h00;
  localparam logic [APB_ADDR_WIDTH-1:0] DECAY_ADDR           = 8'h04;
  localparam logic [APB_ADDR_WIDTH-1:0] SUSTAIN_ADDR         = 8'h08;
  localparam logic [APB_ADDR_WIDTH-1:0] RELEASE_ADDR         = 8'h0C;
  localparam logic [APB_ADDR_WIDTH-1:0] PHASE_INCREMENT_ADDR = 8'h10;
  localparam logic [APB_ADDR_WIDTH-1:0] COMMAND_ADDR         = 8'h14;
  localparam logic [APB_ADDR_WIDTH-1:0] STATUS_ADDR          = 8'h18;

  // command word bits
  localparam int COMMAND_NOTE_ON_BIT  = 0;
  localparam int COMMAND_NOTE_OFF_BIT = 1;

endpackage

// File: hdl/phase_oscillator.sv
`timescale 1ns/10ps

module phase_oscillator
  import synth_config_pkg::*;
(
  input  logic                              clock_50_000_000,
  input  logic                              reset_l,
  input  logic                              sample_tick,
  voice_control_if.oscillator               control,
  output logic signed [AUDIO_BIT_WIDTH-1:0] osc_sample
);

  logic [PHASE_WIDTH-1:0] phase;

  always_ff @(posedge clock_50_000_000, negedge reset_l) begin
    if (!reset_l) begin
      phase <= '0;
    end else if (sample_tick) begin
      phase <= phase + control.phase_increment;
    end
  end

  // offset binary to two's complement, phase 0 is the most negative sample
  assign osc_sample = {~phase[PHASE_WIDTH-1],
                       phase[PHASE_WIDTH-2 -: AUDIO_BIT_WIDTH-1]};

endmodule

// File: hdl/reciprocal_rom.sv
`timescale 1ns/10ps

module reciprocal_rom
  import synth_config_pkg::*;
(
  input  logic                              clock_50_000_000,
  input  logic [ENVELOPE_COUNTER_WIDTH-1:0] divisor,
  output logic [ENVELOPE_COUNTER_WIDTH-1:0] reciprocal
);

  typedef logic [(1 << ENVELOPE_COUNTER_WIDTH)-1:0][ENVELOPE_COUNTER_WIDTH-1:0] table_t;

  // entry i holds 255 / i, index 0 saturates
  function automatic table_t build_table();
    table_t entries;
    entries[0] = ENVELOPE_COUNTER_WIDTH'(MAX_TARGET_TICKS);
    for (int i = 1; i < (1 << ENVELOPE_COUNTER_WIDTH); i++) begin
      entries[i] = ENVELOPE_COUNTER_WIDTH'(MAX_TARGET_TICKS / i);
    end
    return entries;
  endfunction

  localparam table_t RECIPROCAL_TABLE = build_table();

  always_ff @(posedge clock_50_000_000) begin
    reciprocal <= RECIPROCAL_TABLE[divisor];
  end

endmodule

// File: hdl/sample_tick_generator.sv
`timescale 1ns/10ps

module sample_tick_generator
  import synth_config_pkg::*;
(
  input  logic clock_50_000_000,
  input  logic reset_l,
  output logic sample_tick
);

  logic [TICK_COUNTER_WIDTH-1:0] tick_count;

  always_ff @(posedge clock_50_000_000, negedge reset_l) begin
    if (!reset_l) begin
      tick_count  <= '0;
      sample_tick <= 1'b0;
    end else if (tick_count == TICK_COUNTER_WIDTH'(GENERATION_TICKS - 1)) begin
      tick_count  <= '0;
      sample_tick <= 1'b1;
    end else begin
      tick_count  <= tick_count + 1'b1;
      sample_tick <= 1'b0;
    end
  end

  a_tick_single_cycle: assert property (
    @(posedge clock_50_000_000) disable iff (!reset_l)
    sample_tick |=> !sample_tick
  ) else $error("sample tick held for two cycles");

endmodule

// File: hdl/synth_config_pkg.sv
package synth_config_pkg;

  // ----------------------------------------------------------
  // clocking and sample rate
  // ----------------------------------------------------------
  localparam int SYSTEM_CLOCK               = 50_000_000;
  localparam int AUDIO_GENERATION_FREQUENCY = 48_000;
  localparam int GENERATION_TICKS           = SYSTEM_CLOCK / AUDIO_GENERATION_FREQUENCY;
  localparam int TICK_COUNTER_WIDTH         = $clog2(GENERATION_TICKS);

  // ----------------------------------------------------------
  // datapath widths
  // ----------------------------------------------------------
  localparam int AUDIO_BIT_WIDTH        = 16;
  localparam int PERCENT_WIDTH          = 8;
  localparam int ENVELOPE_COUNTER_WIDTH = 8;
  localparam int ENVELOPE_PUSH_BITS     = AUDIO_BIT_WIDTH - ENVELOPE_COUNTER_WIDTH;
  localparam int PHASE_WIDTH            = 24;

  // longest stage in samples, and full scale of a setting
  localparam int MAX_TARGET_TICKS = 255;
  localparam int PARAM_CEILING    = 256;

endpackage

// File: hdl/synth_voice_top.sv
`timescale 1ns/10ps

module synth_voice_top
  import synth_config_pkg::*, envelope_pkg::*;
(
  input  logic                              clock_50_000_000,
  input  logic                              reset_l,
  input  logic [APB_ADDR_WIDTH-1:0]         paddr,
  input  logic                              psel,
  input  logic                              penable,
  input  logic                              pwrite,
  input  logic [31:0]                       pwdata,
  output logic [31:0]                       prdata,
  output logic                              pready,
  output logic                              pslverr,
  output logic signed [AUDIO_BIT_WIDTH-1:0] sample_out,
  output logic                              sample_valid,
  output logic [AUDIO_BIT_WIDTH-1:0]        envelope,
  output logic                              envelope_end
);

  logic                              sample_tick;
  logic [ENVELOPE_COUNTER_WIDTH-1:0] divisor;
  logic [ENVELOPE_COUNTER_WIDTH-1:0] reciprocal;
  logic signed [AUDIO_BIT_WIDTH-1:0] osc_sample;

  voice_control_if control ();

  adsr_register_file u_register_file (
    .clock_50_000_000 (clock_50_000_000),
    .reset_l          (reset_l),
    .paddr            (paddr),
    .psel             (psel),
    .penable          (penable),
    .pwrite           (pwrite),
    .pwdata           (pwdata),
    .prdata           (prdata),
    .pready           (pready),
    .pslverr          (pslverr),
    .envelope_end     (envelope_end),
    .control          (control)
  );

  sample_tick_generator u_tick (
    .clock_50_000_000 (clock_50_000_000),
    .reset_l          (reset_l),
    .sample_tick      (sample_tick)
  );

  // ----------------------------------------------------------
  // envelope with its reciprocal table
  // ----------------------------------------------------------
  reciprocal_rom u_reciprocal_rom (
    .clock_50_000_000 (clock_50_000_000),
    .divisor          (divisor),
    .reciprocal       (reciprocal)
  );

  adsr_envelope u_envelope (
    .clock_50_000_000 (clock_50_000_000),
    .reset_l          (reset_l),
    .sample_tick      (sample_tick),
    .control          (control),
    .divisor          (divisor),
    .reciprocal       (reciprocal),
    .envelope         (envelope),
    .envelope_end     (envelope_end)
  );

  // ----------------------------------------------------------
  // audio path
  // ----------------------------------------------------------
  phase_oscillator u_oscillator (
    .clock_50_000_000 (clock_50_000_000),
    .reset_l          (reset_l),
    .sample_tick      (sample_tick),
    .control          (control),
    .osc_sample       (osc_sample)
  );

  voice_amplifier u_amplifier (
    .clock_50_000_000 (clock_50_000_000),
    .reset_l          (reset_l),
    .sample_tick      (sample_tick),
    .osc_sample       (osc_sample),
    .envelope         (envelope),
    .sample_out       (sample_out),
    .sample_valid     (sample_valid)
  );

endmodule

// File: hdl/voice_amplifier.sv
`timescale 1ns/10ps

module voice_amplifier
  import synth_config_pkg::*;
(
  input  logic                              clock_50_000_000,
  input  logic                              reset_l,
  input  logic                              sample_tick,
  input  logic signed [AUDIO_BIT_WIDTH-1:0] osc_sample,
  input  logic        [AUDIO_BIT_WIDTH-1:0] envelope,
  output logic signed [AUDIO_BIT_WIDTH-1:0] sample_out,
  output logic                              sample_valid
);

  logic signed [2*AUDIO_BIT_WIDTH:0] product;
  logic signed [2*AUDIO_BIT_WIDTH:0] scaled;

  // envelope is unsigned gain, so widen it by a zero sign bit
  assign product = osc_sample * $signed({1'b0, envelope});
  assign scaled  = product >>> AUDIO_BIT_WIDTH;

  always_ff @(posedge clock_50_000_000, negedge reset_l) begin
    if (!reset_l) begin
      sample_out   <= '0;
      sample_valid <= 1'b0;
    end else begin
      sample_valid <= sample_tick;
      if (sample_tick) begin
        sample_out <= scaled[AUDIO_BIT_WIDTH-1:0];
      end
    end
  end

endmodule

// File: hdl/voice_control_if.sv
`timescale 1ns/10ps

interface voice_control_if
  import synth_config_pkg::*, envelope_pkg::*;
();

  parameter_t             parameters;
  logic                   note_on;
  logic                   note_off;
  logic [PHASE_WIDTH-1:0] phase_increment;

  // register file drives everything
  modport source (output parameters, note_on, note_off, phase_increment);

  modport envelope (input parameters, note_on, note_off);

  modport oscillator (input phase_increment);

endinterface

// File: run_sim.sh
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f files.f --top-module synth_voice_tb \
  --Mdir "$BUILD_DIR" -o synth_voice_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$BUILD_DIR/synth_voice_sim" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -q "^STATUS: PASS$" "$LOG_FILE"; then
  echo "simulation passed"
  exit 0
fi
echo "simulation failed, see $LOG_FILE"
exit 1

// File: testbench/synth_voice_tb.sv
`timescale 1ns/10ps

module synth_voice_tb
  import synth_config_pkg::*, envelope_pkg::*;
();

  localparam logic [1:0] STEP_WRITE    = 2'd0;
  localparam logic [1:0] STEP_READ     = 2'd1;
  localparam logic [1:0] STEP_WAIT_END = 2'd2;
  localparam logic [1:0] STEP_SUSTAIN  = 2'd3;

  localparam logic [APB_ADDR_WIDTH-1:0] UNMAPPED_ADDR = 8'h1C;

  // note settings for the envelope sections
  localparam int NOTE_ATTACK  = 16;
  localparam int NOTE_DECAY   = 16;
  localparam int NOTE_SUSTAIN = 128;
  localparam int NOTE_RELEASE = 16;

  // attack of 16 ends at 15 * 17 in the top byte
  localparam logic [AUDIO_BIT_WIDTH-1:0] ATTACK_PEAK_FLOOR = 16'hFF00;

  typedef struct packed {
    logic [1:0]                 kind;
    logic [APB_ADDR_WIDTH-1:0]  addr;
    logic [31:0]                data;
    logic [31:0]                mask;
    logic                       err;
    logic                       level;
    logic [31:0]                timeout;
    logic [15:0]                samples;
    logic [AUDIO_BIT_WIDTH-1:0] env;
    logic [AUDIO_BIT_WIDTH-1:0] sample;
    logic [AUDIO_BIT_WIDTH-1:0] peak;
  } step_t;

  logic                              clock_50_000_000;
  logic                              reset_l;
  logic [APB_ADDR_WIDTH-1:0]         paddr;
  logic                              psel;
  logic                              penable;
  logic                              pwrite;
  logic [31:0]                       pwdata;
  logic [31:0]                       prdata;
  logic                              pready;
  logic                              pslverr;
  logic signed [AUDIO_BIT_WIDTH-1:0] sample_out;
  logic                              sample_valid;
  logic [AUDIO_BIT_WIDTH-1:0]        envelope;
  logic                              envelope_end;

  step_t steps[$];
  int    mismatch_count = 0;
  int    timeout_count = 0;

  synth_voice_top DUT (.*);

  initial begin
    clock_50_000_000 = 1'b0;
    forever #10 clock_50_000_000 = ~clock_50_000_000;
  end

  // ----------------------------------------------------------
  // checks and timing helpers
  // ----------------------------------------------------------
  task automatic check_value(input string what, input int actual, input int expected);
    if (actual != expected) begin
      $display("MISMATCH at %0t: %s, got %0d, expected %0d", $time, what, actual, expected);
      mismatch_count++;
    end
  endtask

  task automatic report_timeout(input string what);
    $display("TIMEOUT at %0t: %s", $time, what);
    timeout_count++;
  endtask

  // inputs change a little after the rising edge
  task automatic next_cycle();
    @(posedge clock_50_000_000);
    #2;
  endtask

  function automatic int stage_samples(input int setting);
    return (MAX_TARGET_TICKS * setting) >> PERCENT_WIDTH;
  endfunction

  // ----------------------------------------------------------
  // APB transfers, response sampled mid access cycle
  // ----------------------------------------------------------
  task automatic apb_write(input logic [APB_ADDR_WIDTH-1:0] addr, input logic [31:0] data,
                           output logic err);
    paddr   = addr;
    pwdata  = data;
    pwrite  = 1'b1;
    psel    = 1'b1;
    penable = 1'b0;
    next_cycle();
    penable = 1'b1;
    @(negedge clock_50_000_000);
    err = pslverr;
    next_cycle();
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read(input logic [APB_ADDR_WIDTH-1:0] addr, output logic [31:0] data,
                          output logic err);
    paddr   = addr;
    pwrite  = 1'b0;
    psel    = 1'b1;
    penable = 1'b0;
    next_cycle();
    penable = 1'b1;
    @(negedge clock_50_000_000);
    data = prdata;
    err  = pslverr;
    next_cycle();
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic wait_for_end(input logic level, input int timeout);
    int                         cycles;
    logic [AUDIO_BIT_WIDTH-1:0] previous;
    cycles   = 0;
    previous = envelope;
    while (!(envelope_end == level && envelope == '0) && cycles < timeout) begin
      next_cycle();
      cycles++;
      // release only moves toward silence
      if (level && envelope > previous) begin
        check_value("envelope rose during release", int'(envelope), int'(previous));
      end
      previous = envelope;
    end
    if (!(envelope_end == level && envelope == '0)) begin
      report_timeout($sformatf("envelope_end never reached %0d with a silent envelope", level));
    end
  endtask

  task automatic check_sustain(input logic [AUDIO_BIT_WIDTH-1:0] expected_env,
                               input logic [AUDIO_BIT_WIDTH-1:0] expected_sample,
                               input int samples, input logic [AUDIO_BIT_WIDTH-1:0] min_peak,
                               input int timeout);
    int                         cycles;
    int                         n;
    logic                       rising;
    logic [AUDIO_BIT_WIDTH-1:0] previous;
    logic [AUDIO_BIT_WIDTH-1:0] peak;
    cycles   = 0;
    rising   = 1'b1;
    previous = envelope;
    peak     = envelope;
    while ((rising || envelope != expected_env) && cycles < timeout) begin
      next_cycle();
      cycles++;
      if (rising && envelope < previous) begin
        rising = 1'b0;
        if (peak < min_peak) begin
          check_value("envelope fell before the attack peak", int'(peak), int'(min_peak));
        end
      end
      if (envelope > peak) begin
        peak = envelope;
      end
      previous = envelope;
    end
    if (rising || envelope != expected_env) begin
      report_timeout("envelope did not settle at the sustain height");
    end else begin
      // this strobe still carries the last decay gain
      next_cycle();
      for (n = 0; n < samples; n++) begin
        cycles = 0;
        while (!sample_valid && cycles < 2 * GENERATION_TICKS) begin
          next_cycle();
          cycles++;
        end
        if (!sample_valid) begin
          report_timeout("no sample_valid strobe during sustain");
          break;
        end
        check_value("sample_out in sustain", int'(sample_out), int'($signed(expected_sample)));
        check_value("envelope in sustain", int'(envelope), int'(expected_env));
        next_cycle();
      end
    end
  endtask

  // ----------------------------------------------------------
  // stimulus table
  // ----------------------------------------------------------
  task automatic write_row(input logic [APB_ADDR_WIDTH-1:0] addr, input logic [31:0] data,
                           input logic err);
    step_t s;
    s      = '0;
    s.kind = STEP_WRITE;
    s.addr = addr;
    s.data = data;
    s.err  = err;
    steps.push_back(s);
  endtask

  task automatic read_row(input logic [APB_ADDR_WIDTH-1:0] addr, input logic [31:0] data,
                          input logic [31:0] mask, input logic err);
    step_t s;
    s      = '0;
    s.kind = STEP_READ;
    s.addr = addr;
    s.data = data;
    s.mask = mask;
    s.err  = err;
    steps.push_back(s);
  endtask

  task automatic end_wait_row(input logic level, input int timeout);
    step_t s;
    s         = '0;
    s.kind    = STEP_WAIT_END;
    s.level   = level;
    s.timeout = 32'(timeout);
    steps.push_back(s);
  endtask

  task automatic sustain_row(input logic [AUDIO_BIT_WIDTH-1:0] env,
                             input logic [AUDIO_BIT_WIDTH-1:0] sample, input int samples,
                             input logic [AUDIO_BIT_WIDTH-1:0] peak, input int timeout);
    step_t s;
    s         = '0;
    s.kind    = STEP_SUSTAIN;
    s.env     = env;
    s.sample  = sample;
    s.samples = 16'(samples);
    s.peak    = peak;
    s.timeout = 32'(timeout);
    steps.push_back(s);
  endtask

  task automatic build_table();
    logic [APB_ADDR_WIDTH-1:0]  setting_addr [4];
    logic [PERCENT_WIDTH-1:0]   setting [4];
    logic [PHASE_WIDTH-1:0]     increment;
    logic [AUDIO_BIT_WIDTH-1:0] height;
    logic [AUDIO_BIT_WIDTH-1:0] quiet_sample;
    int                         rise_timeout;
    int                         release_timeout;
    int                         i;
    setting_addr = '{ATTACK_ADDR, DECAY_ADDR, SUSTAIN_ADDR, RELEASE_ADDR};
    for (i = 0; i < 4; i++) begin
      setting[i] = PERCENT_WIDTH'($urandom);
    end
    increment = PHASE_WIDTH'($urandom);

    // readback finishes well before the first sample tick moves the phase
    for (i = 0; i < 4; i++) begin
      write_row(setting_addr[i], 32'(setting[i]), 1'b0);
    end
    write_row(PHASE_INCREMENT_ADDR, 32'(increment), 1'b0);
    for (i = 0; i < 4; i++) begin
      read_row(setting_addr[i], 32'(setting[i]), '1, 1'b0);
    end
    read_row(PHASE_INCREMENT_ADDR, 32'(increment), '1, 1'b0);
    read_row(COMMAND_ADDR, 32'd0, '1, 1'b0);
    read_row(UNMAPPED_ADDR, 32'd0, 32'd0, 1'b1);
    write_row(STATUS_ADDR, 32'd1, 1'b1);
    read_row(STATUS_ADDR, 32'd1, '1, 1'b0);

    // phase 0 is the most negative sample, so the output is minus half the gain
    height          = AUDIO_BIT_WIDTH'(NOTE_SUSTAIN) << (AUDIO_BIT_WIDTH - PERCENT_WIDTH);
    quiet_sample    = AUDIO_BIT_WIDTH'(-(int'(height) / 2));
    rise_timeout    = (stage_samples(NOTE_ATTACK) + stage_samples(NOTE_DECAY) + 6)
                      * GENERATION_TICKS;
    release_timeout = (stage_samples(NOTE_RELEASE) + 4) * GENERATION_TICKS;

    write_row(ATTACK_ADDR, 32'(NOTE_ATTACK), 1'b0);
    write_row(DECAY_ADDR, 32'(NOTE_DECAY), 1'b0);
    write_row(SUSTAIN_ADDR, 32'(NOTE_SUSTAIN), 1'b0);
    write_row(RELEASE_ADDR, 32'(NOTE_RELEASE), 1'b0);
    write_row(PHASE_INCREMENT_ADDR, 32'd0, 1'b0);
    write_row(COMMAND_ADDR, 32'h1, 1'b0);
    end_wait_row(1'b0, 1);
    read_row(STATUS_ADDR, 32'd0, '1, 1'b0);
    sustain_row(height, quiet_sample, 4, ATTACK_PEAK_FLOOR, rise_timeout);

    write_row(COMMAND_ADDR, 32'h2, 1'b0);
    end_wait_row(1'b1, release_timeout);
    read_row(STATUS_ADDR, 32'd1, '1, 1'b0);

    // retrigger while the release is underway
    write_row(COMMAND_ADDR, 32'h1, 1'b0);
    end_wait_row(1'b0, 1);
    sustain_row(height, quiet_sample, 1, ATTACK_PEAK_FLOOR, rise_timeout);
    write_row(COMMAND_ADDR, 32'h2, 1'b0);
    read_row(STATUS_ADDR, 32'd0, '1, 1'b0);
    write_row(COMMAND_ADDR, 32'h1, 1'b0);
    end_wait_row(1'b0, 1);
    sustain_row(height, quiet_sample, 1, ATTACK_PEAK_FLOOR, rise_timeout);
  endtask

  task automatic run_step(input step_t s);
    logic [31:0] data;
    logic        err;
    case (s.kind)
      STEP_WRITE: begin
        apb_write(s.addr, s.data, err);
        check_value($sformatf("pslverr of write to 0x%02h", s.addr), int'(err), int'(s.err));
      end
      STEP_READ: begin
        apb_read(s.addr, data, err);
        check_value($sformatf("pslverr of read from 0x%02h", s.addr), int'(err), int'(s.err));
        if (s.mask != '0) begin
          check_value($sformatf("prdata of read from 0x%02h", s.addr),
                      int'(data & s.mask), int'(s.data & s.mask));
        end
      end
      STEP_WAIT_END: wait_for_end(s.level, int'(s.timeout));
      default: check_sustain(s.env, s.sample, int'(s.samples), s.peak, int'(s.timeout));
    endcase
  endtask

  // ----------------------------------------------------------
  // main sequence
  // ----------------------------------------------------------
  initial begin
    reset_l = 1'b0;
    paddr   = '0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    pwdata  = '0;
    void'($urandom(71));
    build_table();

    repeat (8) @(posedge clock_50_000_000);
    #2;
    reset_l = 1'b1;

    check_value("envelope_end after reset", int'(envelope_end), 1);
    check_value("envelope after reset", int'(envelope), 0);
    check_value("sample_valid after reset", int'(sample_valid), 0);
    check_value("sample_out after reset", int'(sample_out), 0);
    check_value("pslverr after reset", int'(pslverr), 0);
    check_value("pready after reset", int'(pready), 1);

    foreach (steps[i]) begin
      run_step(steps[i]);
    end

    $display("run finished with %0d mismatches and %0d timeouts",
             mismatch_count, timeout_count);
    if (mismatch_count == 0 && timeout_count == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule
